/* radio_ctrl.f */
src/radio_regs_pkg.sv
src/radio_status_pkg.sv
src/settings_ctrl.sv
src/misc_regs.sv
src/vita_time.sv
src/event_timer.sv
src/irq_collector.sv
src/radio_ctrl_core.sv
verif/tb_radio_ctrl.sv

/* Makefile */
# Verilator build and run for the radio control core
# Override any variable on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= tb_radio_ctrl
FILELIST  ?= radio_ctrl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal
FAIL_MSG  ?= Done: errors found
PASS_MSG  ?= Done: no errors

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/radio_ctrl_vectors.txt */
# Columns: command, test number (decimal), address (hex), value (hex)
# W write, R readback, S status pins, P pps pulse, I wait for irq_o, L output group
S 1 00 00000531
L 1 00 08
L 1 04 1
L 1 01 0
R 1 0C 00000005
I 1 00 0
R 1 09 80000005
W 2 03 A5
W 2 08 0F
S 2 00 0000053E
L 2 00 A6
W 2 08 F0
L 2 00 15
W 3 C0 00001234
W 3 C1 00000000
W 3 C2 1
R 3 0A 00001234
W 4 C0 0000ABCD
W 4 C2 0
R 4 0A 00001234
W 4 C9 FF
W 4 C8 04
P 4 00 0
R 4 0A 0000ABCD
R 4 0E 0000ABCD
R 4 0D 00000004
I 4 00 1
W 4 C9 04
I 4 00 0
W 5 C8 01
W 5 C6 14
I 5 00 1
R 5 0D 00000001
W 5 C9 01
I 5 00 0
W 5 C8 02
W 5 C7 0A
I 5 00 1
W 5 C9 02
I 5 00 0
I 5 00 1
W 5 C7 0
W 5 C9 FF
I 5 00 0
W 6 C9 FF
W 6 C8 08
S 6 00 0000052E
I 6 00 1
R 6 0D 00000008
W 6 04 1
L 6 04 0
W 6 00 15
L 6 01 15
W 6 01 9
L 6 02 9
W 6 02 6
L 6 03 6

/* verif/tb_radio_ctrl.sv */
// Testbench for the radio control core
// Reads command vectors, drives settings, readback and status inputs, checks outputs

module tb_radio_ctrl;
   timeunit 1ns;
   timeprecision 100ps;

   import radio_regs_pkg::*;
   import radio_status_pkg::*;

   localparam int    TIMEOUT_CYCLES = 200;
   localparam string VEC_FILE       = "verif/radio_ctrl_vectors.txt";

   logic                  dsp_clk;
   logic                  rst_i;
   logic                  set_stb_i;
   logic [SET_ADDR_W-1:0] set_addr_i;
   logic [SET_DATA_W-1:0] set_data_i;
   logic                  rd_stb_i;
   logic [RB_ADDR_W-1:0]  rd_addr_i;
   logic [SET_DATA_W-1:0] rd_data_o;
   logic                  rd_ack_o;
   logic                  pps_i;
   logic                  phy_int_n_i;
   logic                  clk_status_i;
   logic                  link_up_i;
   logic                  run_rx_i;
   logic                  run_tx_i;
   logic                  sim_mode_i;
   logic [3:0]            clock_divider_i;
   logic                  clock_ready_o;
   logic [1:0]            clk_en_o;
   logic [1:0]            clk_sel_o;
   logic                  ser_enable_o;
   logic                  ser_prbsen_o;
   logic                  ser_loopen_o;
   logic                  ser_rx_en_o;
   logic                  adc_oe_a_o;
   logic                  adc_on_a_o;
   logic                  adc_oe_b_o;
   logic                  adc_on_b_o;
   logic                  phy_reset_n_o;
   logic [LED_W-1:0]      leds_o;
   logic                  irq_o;

   int cur_test;
   int test_checks;
   int test_errors;
   int test_total;
   int check_total;
   int error_count;

   radio_ctrl_core i_radio_ctrl_core (
      .dsp_clk(dsp_clk), .rst_i(rst_i),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .rd_stb_i(rd_stb_i), .rd_addr_i(rd_addr_i), .rd_data_o(rd_data_o), .rd_ack_o(rd_ack_o),
      .pps_i(pps_i), .phy_int_n_i(phy_int_n_i), .clk_status_i(clk_status_i),
      .link_up_i(link_up_i), .run_rx_i(run_rx_i), .run_tx_i(run_tx_i),
      .sim_mode_i(sim_mode_i), .clock_divider_i(clock_divider_i),
      .clock_ready_o(clock_ready_o), .clk_en_o(clk_en_o), .clk_sel_o(clk_sel_o),
      .ser_enable_o(ser_enable_o), .ser_prbsen_o(ser_prbsen_o),
      .ser_loopen_o(ser_loopen_o), .ser_rx_en_o(ser_rx_en_o),
      .adc_oe_a_o(adc_oe_a_o), .adc_on_a_o(adc_on_a_o),
      .adc_oe_b_o(adc_oe_b_o), .adc_on_b_o(adc_on_b_o),
      .phy_reset_n_o(phy_reset_n_o), .leds_o(leds_o), .irq_o(irq_o)
   );

   // 4 ns period
   initial begin
      dsp_clk = 1'b0;
      forever #2 dsp_clk = ~dsp_clk;
   end

   //////////////////////////////////////////////////
   // Bookkeeping

   task automatic record_error();
      error_count++;
      test_errors++;
   endtask

   task automatic close_test();
      if (test_errors == 0)
         $display("Test %0d ok, %0d checks", cur_test, test_checks);
      else
         $display("Test %0d had %0d errors in %0d checks", cur_test, test_errors, test_checks);
      test_total++;
      check_total += test_checks;
   endtask

   //////////////////////////////////////////////////
   // Bus and pin drivers

   task automatic settings_write(input logic [SET_ADDR_W-1:0] addr,
                                 input logic [SET_DATA_W-1:0] data);
      @(posedge dsp_clk);
      #1;
      set_stb_i  = 1'b1;
      set_addr_i = addr;
      set_data_i = data;
      @(posedge dsp_clk);
      #1;
      set_stb_i = 1'b0;
   endtask

   task automatic readback_check(input logic [RB_ADDR_W-1:0] addr,
                                 input logic [SET_DATA_W-1:0] expected);
      int   cycles;
      logic got_ack;
      cycles  = 0;
      got_ack = 1'b0;
      @(posedge dsp_clk);
      #1;
      rd_stb_i  = 1'b1;
      rd_addr_i = addr;
      while (!got_ack && cycles < TIMEOUT_CYCLES) begin
         @(posedge dsp_clk);
         #1;
         rd_stb_i = 1'b0;
         got_ack  = rd_ack_o;
         cycles++;
      end
      test_checks++;
      if (!got_ack) begin
         $display("Readback of word %0d got no acknowledge within %0d cycles",
                  addr, TIMEOUT_CYCLES);
         record_error();
      end else begin
         if (cycles != 1) begin
            $display("Readback of word %0d acknowledged %0d cycles after the strobe",
                     addr, cycles);
            record_error();
         end
         if (rd_data_o !== expected) begin
            $display("[FAIL] rd_data_o word %0d: got %h, expected %h", addr, rd_data_o, expected);
            record_error();
         end
         // Acknowledge lasts a single cycle
         @(posedge dsp_clk);
         #1;
         if (rd_ack_o !== 1'b0) begin
            $display("[FAIL] rd_ack_o one cycle later: got %h, expected %h", rd_ack_o, 1'b0);
            record_error();
         end
      end
   endtask

   // Value bits: rx, tx, clk_status, link_up, phy_int_n, sim_mode, divider in 11..8
   task automatic set_status(input logic [31:0] value);
      @(posedge dsp_clk);
      #1;
      run_rx_i        = value[0];
      run_tx_i        = value[1];
      clk_status_i    = value[2];
      link_up_i       = value[3];
      phy_int_n_i     = value[4];
      sim_mode_i      = value[5];
      clock_divider_i = value[11:8];
   endtask

   task automatic pps_pulse();
      @(posedge dsp_clk);
      #1;
      pps_i = 1'b1;
      repeat (4) @(posedge dsp_clk);
      #1;
      pps_i = 1'b0;
      // Well past the synchroniser delay
      repeat (8) @(posedge dsp_clk);
   endtask

   task automatic wait_irq(input logic expected);
      int cycles;
      cycles = 0;
      @(posedge dsp_clk);
      #1;
      while (irq_o !== expected && cycles < TIMEOUT_CYCLES) begin
         @(posedge dsp_clk);
         #1;
         cycles++;
      end
      test_checks++;
      if (irq_o !== expected) begin
         $display("Timed out after %0d cycles waiting for irq_o to become %0d",
                  TIMEOUT_CYCLES, expected);
         record_error();
      end
   endtask

   // Selector 0 LEDs, 1 clock lines, 2 SERDES, 3 ADC, 4 PHY reset
   task automatic output_check(input logic [3:0] sel, input logic [31:0] expected);
      logic [31:0] got;
      string       name;
      logic        known;
      known = 1'b1;
      got   = '0;
      name  = "";
      @(posedge dsp_clk);
      @(posedge dsp_clk);
      #1;
      case (sel)
         4'd0: begin
            got  = {{(32-LED_W){1'b0}}, leds_o};
            name = "leds_o";
         end
         4'd1: begin
            got  = {27'd0, clock_ready_o, clk_en_o, clk_sel_o};
            name = "clock_ready_o,clk_en_o,clk_sel_o";
         end
         4'd2: begin
            got  = {28'd0, ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o};
            name = "ser_enable_o,ser_prbsen_o,ser_loopen_o,ser_rx_en_o";
         end
         4'd3: begin
            got  = {28'd0, adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o};
            name = "adc_oe_a_o,adc_on_a_o,adc_oe_b_o,adc_on_b_o";
         end
         4'd4: begin
            got  = {31'd0, phy_reset_n_o};
            name = "phy_reset_n_o";
         end
         default: known = 1'b0;
      endcase
      test_checks++;
      if (!known) begin
         $display("Output check in test %0d names unknown output group %0d", cur_test, sel);
         record_error();
      end else if (got !== expected) begin
         $display("[FAIL] %s: got %h, expected %h", name, got, expected);
         record_error();
      end
   endtask

   task automatic run_command(input byte cmd, input logic [31:0] addr,
                              input logic [31:0] value);
      case (cmd)
         "W": settings_write(addr[SET_ADDR_W-1:0], value);
         "R": readback_check(addr[RB_ADDR_W-1:0], value);
         "S": set_status(value);
         "P": pps_pulse();
         "I": wait_irq(value[0]);
         "L": output_check(addr[3:0], value);
         default: begin
            $display("Unknown command %c in test %0d", cmd, cur_test);
            record_error();
         end
      endcase
   endtask

   //////////////////////////////////////////////////
   // Main sequence

   initial begin
      int          fd;
      int          n;
      string       line;
      byte         cmd;
      int          test_num;
      logic [31:0] addr;
      logic [31:0] value;
      rst_i           = 1'b1;
      set_stb_i       = 1'b0;
      set_addr_i      = '0;
      set_data_i      = '0;
      rd_stb_i        = 1'b0;
      rd_addr_i       = '0;
      pps_i           = 1'b0;
      phy_int_n_i     = 1'b1;
      clk_status_i    = 1'b0;
      link_up_i       = 1'b0;
      run_rx_i        = 1'b0;
      run_tx_i        = 1'b0;
      sim_mode_i      = 1'b0;
      clock_divider_i = '0;
      cur_test        = 0;
      test_checks     = 0;
      test_errors     = 0;
      test_total      = 0;
      check_total     = 0;
      error_count     = 0;
      repeat (16) @(posedge dsp_clk);
      #1;
      rst_i = 1'b0;

      fd = $fopen(VEC_FILE, "r");
      if (fd == 0) begin
         $display("Could not open vector file %s", VEC_FILE);
         error_count++;
      end else begin
         while ($fgets(line, fd) != 0) begin
            if (line.len() >= 2 && line[0] != "#") begin
               n = $sscanf(line, "%c %d %h %h", cmd, test_num, addr, value);
               if (n != 4) begin
                  $display("Malformed vector line: %s", line);
                  record_error();
               end else begin
                  if (test_num != cur_test) begin
                     if (cur_test != 0)
                        close_test();
                     cur_test    = test_num;
                     test_checks = 0;
                     test_errors = 0;
                  end
                  run_command(cmd, addr, value);
               end
            end
         end
         $fclose(fd);
         if (cur_test != 0)
            close_test();
      end

      $display("Tests: %0d, checks: %0d, errors: %0d", test_total, check_total, error_count);
      if (error_count == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

/* src/radio_ctrl_core.sv */
// Top level of the radio control and status core
// Settings decode, misc registers, VITA time, event timer and interrupts

module radio_ctrl_core (
   input  logic                                 dsp_clk,
   input  logic                                 rst_i,
   input  logic                                 set_stb_i,
   input  logic [radio_regs_pkg::SET_ADDR_W-1:0] set_addr_i,
   input  logic [radio_regs_pkg::SET_DATA_W-1:0] set_data_i,
   input  logic                                 rd_stb_i,
   input  logic [radio_status_pkg::RB_ADDR_W-1:0] rd_addr_i,
   output logic [radio_regs_pkg::SET_DATA_W-1:0] rd_data_o,
   output logic                                 rd_ack_o,
   input  logic                                 pps_i,
   input  logic                                 phy_int_n_i,
   input  logic                                 clk_status_i,
   input  logic                                 link_up_i,
   input  logic                                 run_rx_i,
   input  logic                                 run_tx_i,
   input  logic                                 sim_mode_i,
   input  logic [3:0]                           clock_divider_i,
   output logic                                 clock_ready_o,
   output logic [1:0]                           clk_en_o,
   output logic [1:0]                           clk_sel_o,
   output logic                                 ser_enable_o,
   output logic                                 ser_prbsen_o,
   output logic                                 ser_loopen_o,
   output logic                                 ser_rx_en_o,
   output logic                                 adc_oe_a_o,
   output logic                                 adc_on_a_o,
   output logic                                 adc_oe_b_o,
   output logic                                 adc_on_b_o,
   output logic                                 phy_reset_n_o,
   output logic [radio_regs_pkg::LED_W-1:0]      leds_o,
   output logic                                 irq_o
);
   import radio_regs_pkg::*;
   import radio_status_pkg::*;

   logic [SET_DATA_W-1:0] wr_data;
   logic                  wr_clock, wr_serdes, wr_adc, wr_led_sw, wr_phy, wr_led_src;
   logic                  wr_time_hi, wr_time_lo, wr_time_ctrl;
   logic                  wr_onetime, wr_periodic, wr_irq_mask, wr_irq_clear;
   logic [TIME_W-1:0]     vita_time_now;
   logic [TIME_W-1:0]     vita_time_pps;
   logic                  pps_event, onetime, periodic;
   logic [IRQ_W-1:0]      irq_pending;

   //////////////////////////////////////////////////
   // Settings decode and readback

   settings_ctrl i_settings_ctrl (
      .dsp_clk(dsp_clk), .rst_i(rst_i),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .rd_stb_i(rd_stb_i), .rd_addr_i(rd_addr_i),
      .time_i(vita_time_now), .pps_time_i(vita_time_pps), .irq_pending_i(irq_pending),
      .sim_mode_i(sim_mode_i), .clock_divider_i(clock_divider_i),
      .wr_data_o(wr_data), .wr_clock_o(wr_clock), .wr_serdes_o(wr_serdes),
      .wr_adc_o(wr_adc), .wr_led_sw_o(wr_led_sw), .wr_phy_o(wr_phy),
      .wr_led_src_o(wr_led_src), .wr_time_hi_o(wr_time_hi), .wr_time_lo_o(wr_time_lo),
      .wr_time_ctrl_o(wr_time_ctrl), .wr_onetime_o(wr_onetime),
      .wr_periodic_o(wr_periodic), .wr_irq_mask_o(wr_irq_mask),
      .wr_irq_clear_o(wr_irq_clear), .rd_data_o(rd_data_o), .rd_ack_o(rd_ack_o)
   );

   //////////////////////////////////////////////////
   // Datapath blocks

   misc_regs i_misc_regs (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .wr_data_i(wr_data),
      .wr_clock_i(wr_clock), .wr_serdes_i(wr_serdes), .wr_adc_i(wr_adc),
      .wr_led_sw_i(wr_led_sw), .wr_phy_i(wr_phy), .wr_led_src_i(wr_led_src),
      .run_rx_i(run_rx_i), .run_tx_i(run_tx_i),
      .clk_status_i(clk_status_i), .link_up_i(link_up_i),
      .clock_ready_o(clock_ready_o), .clk_en_o(clk_en_o), .clk_sel_o(clk_sel_o),
      .ser_enable_o(ser_enable_o), .ser_prbsen_o(ser_prbsen_o),
      .ser_loopen_o(ser_loopen_o), .ser_rx_en_o(ser_rx_en_o),
      .adc_oe_a_o(adc_oe_a_o), .adc_on_a_o(adc_on_a_o),
      .adc_oe_b_o(adc_oe_b_o), .adc_on_b_o(adc_on_b_o),
      .phy_reset_n_o(phy_reset_n_o), .leds_o(leds_o)
   );

   vita_time i_vita_time (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .wr_data_i(wr_data),
      .wr_time_hi_i(wr_time_hi), .wr_time_lo_i(wr_time_lo),
      .wr_time_ctrl_i(wr_time_ctrl), .pps_i(pps_i),
      .time_o(vita_time_now), .pps_time_o(vita_time_pps), .pps_event_o(pps_event)
   );

   event_timer i_event_timer (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .wr_data_i(wr_data),
      .wr_onetime_i(wr_onetime), .wr_periodic_i(wr_periodic),
      .onetime_o(onetime), .periodic_o(periodic)
   );

   irq_collector i_irq_collector (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .wr_data_i(wr_data),
      .wr_irq_mask_i(wr_irq_mask), .wr_irq_clear_i(wr_irq_clear),
      .onetime_i(onetime), .periodic_i(periodic), .pps_event_i(pps_event),
      .phy_int_n_i(phy_int_n_i), .clk_status_i(clk_status_i), .link_up_i(link_up_i),
      .pending_o(irq_pending), .irq_o(irq_o)
   );

endmodule

/* src/irq_collector.sv */
// Edge-triggered interrupt pending register
// Mask, write-one-to-clear and registered interrupt output

module irq_collector (
   input  logic                                 dsp_clk,
   input  logic                                 rst_i,
   input  logic [radio_regs_pkg::SET_DATA_W-1:0] wr_data_i,
   input  logic                                 wr_irq_mask_i,
   input  logic                                 wr_irq_clear_i,
   input  logic                                 onetime_i,
   input  logic                                 periodic_i,
   input  logic                                 pps_event_i,
   input  logic                                 phy_int_n_i,
   input  logic                                 clk_status_i,
   input  logic                                 link_up_i,
   output logic [radio_status_pkg::IRQ_W-1:0]    pending_o,
   output logic                                 irq_o
);
   import radio_status_pkg::*;

   logic [IRQ_W-1:0] src;
   logic [IRQ_W-1:0] src_prev;
   logic [IRQ_W-1:0] rise;
   logic [IRQ_W-1:0] clr;
   logic [IRQ_W-1:0] mask_q;

   always_comb begin
      src                 = '0;
      src[IRQ_ONETIME]    = onetime_i;
      src[IRQ_PERIODIC]   = periodic_i;
      src[IRQ_PPS]        = pps_event_i;
      src[IRQ_PHY]        = ~phy_int_n_i;
      src[IRQ_CLK_STATUS] = clk_status_i;
      src[IRQ_LINK_UP]    = link_up_i;
   end

   assign rise = src & ~src_prev;
   assign clr  = wr_irq_clear_i ? wr_data_i[IRQ_W-1:0] : '0;

   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         src_prev  <= '0;
         pending_o <= '0;
         mask_q    <= '0;
         irq_o     <= 1'b0;
      end else begin
         src_prev <= src;
         // New edge beats a clear on the same bit
         pending_o <= (pending_o & ~clr) | rise;
         if (wr_irq_mask_i)
            mask_q <= wr_data_i[IRQ_W-1:0];
         irq_o <= |(pending_o & mask_q);
      end
   end

endmodule

/* src/event_timer.sv */
// One-shot and periodic countdown timers for the interrupt sources

module event_timer (
   input  logic                                 dsp_clk,
   input  logic                                 rst_i,
   input  logic [radio_regs_pkg::SET_DATA_W-1:0] wr_data_i,
   input  logic                                 wr_onetime_i,
   input  logic                                 wr_periodic_i,
   output logic                                 onetime_o,
   output logic                                 periodic_o
);
   import radio_regs_pkg::*;

   logic [TIMER_W-1:0] one_cnt;
   logic [TIMER_W-1:0] per_cnt;
   logic [TIMER_W-1:0] per_len;

   // One-shot counts down once, then idles at zero
   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         one_cnt   <= '0;
         onetime_o <= 1'b0;
      end else begin
         onetime_o <= 1'b0;
         if (wr_onetime_i) begin
            one_cnt <= wr_data_i[TIMER_W-1:0];
         end else if (one_cnt != '0) begin
            one_cnt   <= one_cnt - 1'b1;
            onetime_o <= (one_cnt == TIMER_W'(1));
         end
      end
   end

   // Periodic reloads from per_len, a zero length stops it
   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         per_len    <= '0;
         per_cnt    <= '0;
         periodic_o <= 1'b0;
      end else begin
         periodic_o <= 1'b0;
         if (wr_periodic_i) begin
            per_len <= wr_data_i[TIMER_W-1:0];
            per_cnt <= wr_data_i[TIMER_W-1:0];
         end else if (per_len != '0) begin
            if (per_cnt == TIMER_W'(1)) begin
               per_cnt    <= per_len;
               periodic_o <= 1'b1;
            end else begin
               per_cnt <= per_cnt - 1'b1;
            end
         end
      end
   end

endmodule

/* src/vita_time.sv */
// 64-bit VITA time counter with immediate or PPS-armed load
// PPS synchroniser, edge detect and time capture

module vita_time (
   input  logic                                 dsp_clk,
   input  logic                                 rst_i,
   input  logic [radio_regs_pkg::SET_DATA_W-1:0] wr_data_i,
   input  logic                                 wr_time_hi_i,
   input  logic                                 wr_time_lo_i,
   input  logic                                 wr_time_ctrl_i,
   input  logic                                 pps_i,
   output logic [radio_regs_pkg::TIME_W-1:0]     time_o,
   output logic [radio_regs_pkg::TIME_W-1:0]     pps_time_o,
   output logic                                 pps_event_o
);
   import radio_regs_pkg::*;

   logic [SET_DATA_W-1:0] stage_hi;
   logic [SET_DATA_W-1:0] stage_lo;
   logic [TIME_W-1:0]     time_stage;
   logic                  armed;
   logic                  pps_meta;
   logic                  pps_sync;
   logic                  pps_prev;
   logic                  pps_rise;
   logic                  pps_load;

   // Two-flop synchroniser then rising edge detect
   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         pps_meta <= 1'b0;
         pps_sync <= 1'b0;
         pps_prev <= 1'b0;
      end else begin
         pps_meta <= pps_i;
         pps_sync <= pps_meta;
         pps_prev <= pps_sync;
      end
   end

   assign pps_rise = pps_sync & ~pps_prev;
   // A fresh control write overrides a pending armed load
   assign pps_load = pps_rise & armed & ~wr_time_ctrl_i;

   always_ff @(posedge dsp_clk) begin
      if (wr_time_hi_i)
         stage_hi <= wr_data_i;
      if (wr_time_lo_i)
         stage_lo <= wr_data_i;
   end

   assign time_stage = {stage_hi, stage_lo};

   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         time_o      <= '0;
         pps_time_o  <= '0;
         pps_event_o <= 1'b0;
         armed       <= 1'b0;
      end else begin
         pps_event_o <= pps_rise;
         time_o      <= time_o + 1'b1;
         if (wr_time_ctrl_i) begin
            // Bit 0 set loads now, clear waits for PPS
            armed <= ~wr_data_i[0];
            if (wr_data_i[0])
               time_o <= time_stage;
         end else if (pps_load) begin
            time_o <= time_stage;
            armed  <= 1'b0;
         end
         // Capture reports the loaded time when the edge also loads
         if (pps_rise)
            pps_time_o <= pps_load ? time_stage : time_o;
      end
   end

endmodule

/* src/misc_regs.sv */
// Clock generator, SERDES, ADC and PHY control registers
// LED registers with the hardware or software source mux

module misc_regs (
   input  logic                                 dsp_clk,
   input  logic                                 rst_i,
   input  logic [radio_regs_pkg::SET_DATA_W-1:0] wr_data_i,
   input  logic                                 wr_clock_i,
   input  logic                                 wr_serdes_i,
   input  logic                                 wr_adc_i,
   input  logic                                 wr_led_sw_i,
   input  logic                                 wr_phy_i,
   input  logic                                 wr_led_src_i,
   input  logic                                 run_rx_i,
   input  logic                                 run_tx_i,
   input  logic                                 clk_status_i,
   input  logic                                 link_up_i,
   output logic                                 clock_ready_o,
   output logic [1:0]                           clk_en_o,
   output logic [1:0]                           clk_sel_o,
   output logic                                 ser_enable_o,
   output logic                                 ser_prbsen_o,
   output logic                                 ser_loopen_o,
   output logic                                 ser_rx_en_o,
   output logic                                 adc_oe_a_o,
   output logic                                 adc_on_a_o,
   output logic                                 adc_oe_b_o,
   output logic                                 adc_on_b_o,
   output logic                                 phy_reset_n_o,
   output logic [radio_regs_pkg::LED_W-1:0]      leds_o
);
   import radio_regs_pkg::*;
   import radio_status_pkg::*;

   logic [CLK_REG_W-1:0] clock_q;
   logic [SER_REG_W-1:0] serdes_q;
   logic [ADC_REG_W-1:0] adc_q;
   logic [LED_W-1:0]     led_sw_q;
   logic [LED_W-1:0]     led_src_q;
   logic                 phy_reset_q;
   logic [LED_W-1:0]     led_hw;

   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         clock_q     <= '0;
         serdes_q    <= '0;
         adc_q       <= '0;
         led_sw_q    <= '0;
         led_src_q   <= LED_SRC_RESET;
         phy_reset_q <= 1'b0;
      end else begin
         if (wr_clock_i)
            clock_q <= wr_data_i[CLK_REG_W-1:0];
         if (wr_serdes_i)
            serdes_q <= wr_data_i[SER_REG_W-1:0];
         if (wr_adc_i)
            adc_q <= wr_data_i[ADC_REG_W-1:0];
         if (wr_led_sw_i)
            led_sw_q <= wr_data_i[LED_W-1:0];
         if (wr_led_src_i)
            led_src_q <= wr_data_i[LED_W-1:0];
         if (wr_phy_i)
            phy_reset_q <= wr_data_i[0];
      end
   end

   assign {clock_ready_o, clk_en_o, clk_sel_o} = clock_q;
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = serdes_q;
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} = adc_q;
   assign phy_reset_n_o = ~phy_reset_q;

   // Hardware status word, unlisted bits stay low
   always_comb begin
      led_hw              = '0;
      led_hw[LED_HW_LINK] = link_up_i;
      led_hw[LED_HW_CLK]  = clk_status_i;
      led_hw[LED_HW_RX]   = run_rx_i;
      led_hw[LED_HW_TX]   = run_tx_i;
   end

   // A 1 in led_src hands the LED to hardware
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

endmodule

/* src/settings_ctrl.sv */
// Settings bus decoder giving one write pulse per register
// Registered readback port for the status words

module settings_ctrl (
   input  logic                                 dsp_clk,
   input  logic                                 rst_i,
   input  logic                                 set_stb_i,
   input  logic [radio_regs_pkg::SET_ADDR_W-1:0] set_addr_i,
   input  logic [radio_regs_pkg::SET_DATA_W-1:0] set_data_i,
   input  logic                                 rd_stb_i,
   input  logic [radio_status_pkg::RB_ADDR_W-1:0] rd_addr_i,
   input  logic [radio_regs_pkg::TIME_W-1:0]     time_i,
   input  logic [radio_regs_pkg::TIME_W-1:0]     pps_time_i,
   input  logic [radio_status_pkg::IRQ_W-1:0]    irq_pending_i,
   input  logic                                 sim_mode_i,
   input  logic [3:0]                           clock_divider_i,
   output logic [radio_regs_pkg::SET_DATA_W-1:0] wr_data_o,
   output logic                                 wr_clock_o,
   output logic                                 wr_serdes_o,
   output logic                                 wr_adc_o,
   output logic                                 wr_led_sw_o,
   output logic                                 wr_phy_o,
   output logic                                 wr_led_src_o,
   output logic                                 wr_time_hi_o,
   output logic                                 wr_time_lo_o,
   output logic                                 wr_time_ctrl_o,
   output logic                                 wr_onetime_o,
   output logic                                 wr_periodic_o,
   output logic                                 wr_irq_mask_o,
   output logic                                 wr_irq_clear_o,
   output logic [radio_regs_pkg::SET_DATA_W-1:0] rd_data_o,
   output logic                                 rd_ack_o
);
   import radio_regs_pkg::*;
   import radio_status_pkg::*;

   // One bit per register, bit 0 is the clock register
   logic [12:0]           wr_q;
   logic [SET_DATA_W-1:0] rb_word;

   //////////////////////////////////////////////////
   // Write decode

   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         wr_q <= '0;
      end else begin
         wr_q <= '0;
         if (set_stb_i) begin
            case (set_addr_i)
               SR_CLOCK:     wr_q[0]  <= 1'b1;
               SR_SERDES:    wr_q[1]  <= 1'b1;
               SR_ADC:       wr_q[2]  <= 1'b1;
               SR_LED_SW:    wr_q[3]  <= 1'b1;
               SR_PHY:       wr_q[4]  <= 1'b1;
               SR_LED_SRC:   wr_q[5]  <= 1'b1;
               SR_TIME_HI:   wr_q[6]  <= 1'b1;
               SR_TIME_LO:   wr_q[7]  <= 1'b1;
               SR_TIME_CTRL: wr_q[8]  <= 1'b1;
               SR_ONETIME:   wr_q[9]  <= 1'b1;
               SR_PERIODIC:  wr_q[10] <= 1'b1;
               SR_IRQ_MASK:  wr_q[11] <= 1'b1;
               SR_IRQ_CLEAR: wr_q[12] <= 1'b1;
               default:      wr_q     <= '0;
            endcase
         end
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (set_stb_i)
         wr_data_o <= set_data_i;
   end

   assign {wr_irq_clear_o, wr_irq_mask_o, wr_periodic_o, wr_onetime_o,
           wr_time_ctrl_o, wr_time_lo_o, wr_time_hi_o, wr_led_src_o,
           wr_phy_o, wr_led_sw_o, wr_adc_o, wr_serdes_o, wr_clock_o} = wr_q;

   //////////////////////////////////////////////////
   // Readback

   always_comb begin
      case (rd_addr_i)
         RB_STRAPS:      rb_word = {sim_mode_i, {(SET_DATA_W-5){1'b0}}, clock_divider_i};
         RB_TIME_HI:     rb_word = time_i[TIME_W-1:SET_DATA_W];
         RB_TIME_LO:     rb_word = time_i[SET_DATA_W-1:0];
         RB_COMPAT:      rb_word = COMPAT_NUM;
         RB_IRQ_PENDING: rb_word = {{(SET_DATA_W-IRQ_W){1'b0}}, irq_pending_i};
         RB_PPS_HI:      rb_word = pps_time_i[TIME_W-1:SET_DATA_W];
         RB_PPS_LO:      rb_word = pps_time_i[SET_DATA_W-1:0];
         default:        rb_word = '0;
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (rst_i)
         rd_ack_o <= 1'b0;
      else
         rd_ack_o <= rd_stb_i;
   end

   always_ff @(posedge dsp_clk) begin
      if (rd_stb_i)
         rd_data_o <= rb_word;
   end

endmodule

/* src/radio_status_pkg.sv */
// Readback word map, interrupt and LED status bit positions
// Compatibility number reported on readback

package radio_status_pkg;

   localparam int RB_ADDR_W = 4;

   typedef enum logic [RB_ADDR_W-1:0] {
      RB_STRAPS      = 4'd9,
      RB_TIME_HI     = 4'd10,
      RB_TIME_LO     = 4'd11,
      RB_COMPAT      = 4'd12,
      RB_IRQ_PENDING = 4'd13,
      RB_PPS_HI      = 4'd14,
      RB_PPS_LO      = 4'd15
   } rb_word_e;

   // Interrupt vector, bits 6 and 7 unused
   localparam int IRQ_W          = 8;
   localparam int IRQ_ONETIME    = 0;
   localparam int IRQ_PERIODIC   = 1;
   localparam int IRQ_PPS        = 2;
   localparam int IRQ_PHY        = 3;
   localparam int IRQ_CLK_STATUS = 4;
   localparam int IRQ_LINK_UP    = 5;

   // Hardware status driving the LEDs
   localparam int LED_HW_LINK = 1;
   localparam int LED_HW_CLK  = 2;
   localparam int LED_HW_RX   = 3;
   localparam int LED_HW_TX   = 4;

   // Bump when the register map changes
   localparam logic [31:0] COMPAT_NUM = 32'd5;

endpackage

/* src/radio_regs_pkg.sv */
// Settings bus address map
// Register widths and reset values of the control core

package radio_regs_pkg;

   // Settings bus
   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;

   typedef enum logic [SET_ADDR_W-1:0] {
      SR_CLOCK     = 8'd0,
      SR_SERDES    = 8'd1,
      SR_ADC       = 8'd2,
      SR_LED_SW    = 8'd3,
      SR_PHY       = 8'd4,
      SR_LED_SRC   = 8'd8,
      // VITA time block
      SR_TIME_HI   = 8'd192,
      SR_TIME_LO   = 8'd193,
      SR_TIME_CTRL = 8'd194,
      // Event timer and interrupts
      SR_ONETIME   = 8'd198,
      SR_PERIODIC  = 8'd199,
      SR_IRQ_MASK  = 8'd200,
      SR_IRQ_CLEAR = 8'd201
   } sr_addr_e;

   // Miscellaneous register widths
   localparam int CLK_REG_W = 5;
   localparam int SER_REG_W = 4;
   localparam int ADC_REG_W = 4;
   localparam int LED_W     = 8;

   // LEDs 1 to 4 follow hardware status out of reset
   localparam logic [LED_W-1:0] LED_SRC_RESET = 8'h1E;

   localparam int TIME_W  = 64;
   localparam int TIMER_W = 32;

endpackage
